// File: Bender.yml
package:
  name: ads_driver

sources:
  - files:
      - src/ads_dev_pkg.sv
      - src/ads_drv_pkg.sv
      - src/power_up_sequencer.sv
      - src/conversion_sequencer.sv
      - src/readout_engine.sv
      - src/ads_driver_top.sv
  - target: test
    files:
      - verif/adc_model.sv
      - verif/tb_ads_driver.sv

// File: ads_driver_top.f
src/ads_dev_pkg.sv
src/ads_drv_pkg.sv
src/power_up_sequencer.sv
src/conversion_sequencer.sv
src/readout_engine.sv
src/ads_driver_top.sv
verif/adc_model.sv
verif/tb_ads_driver.sv

// File: src/ads_dev_pkg.sv
// ADC device definitions

package ads_dev_pkg;

    // Oversampling ratio, coded as on the OS[2:0] pins
    typedef enum logic [2:0] {
        oversamprat_1  = 3'b000,
        oversamprat_2  = 3'b001,
        oversamprat_4  = 3'b010,
        oversamprat_8  = 3'b011,
        oversamprat_16 = 3'b100,
        oversamprat_32 = 3'b101,
        oversamprat_64 = 3'b110
    } oversamprat_t;

    // REFSEL pin
    typedef enum logic {
        ref_source_external = 1'b0,
        ref_source_internal = 1'b1
    } ref_source_t;

    // RANGE pin, 5 V or 10 V full scale
    typedef enum logic {
        range_5v  = 1'b0,
        range_10v = 1'b1
    } range_t;

    // Simultaneously sampled channels
    localparam int chan_cnt = 8;
    typedef logic [$clog2(chan_cnt)-1:0] chan_ix_t;

    // One conversion result per channel
    localparam int sample_width = 18;
    typedef logic [sample_width-1:0] sample_t;

    // All channels of one conversion, channel 0 in the low slot
    typedef sample_t [chan_cnt-1:0] octosample_t;

    // Parallel data bus DB[15:0]
    localparam int db_width = 16;

endpackage

// File: src/ads_driver_top.sv
// ADC parallel driver top level
`timescale 1ns/10ps

module ads_driver_top #(
    parameter ads_dev_pkg::oversamprat_t oversamprat = ads_dev_pkg::oversamprat_1,
    parameter ads_dev_pkg::ref_source_t  ref_source  = ads_dev_pkg::ref_source_internal,
    parameter ads_dev_pkg::range_t       adc_range   = ads_dev_pkg::range_10v,
    parameter int RESET_HIGH_CLKS = 2500,
    parameter int POSTRESET_CLKS  = 1250,
    parameter int SAMPLE_CYC_CLKS = 100,
    parameter int CONVST_CLKS     = 2,
    parameter int RDDB_CLKS       = 2,
    parameter int HOLD_CLKS       = 1,
    parameter int RD_LOW_CLKS     = 1
) (
    input  logic                             clk,
    input  logic                             reset_sn,
    input  logic                             busy,
    input  logic [ads_dev_pkg::db_width-1:0] db,
    output logic                             conv_cnt,
    output logic                             samp_cnt,
    output logic                             octosample_valid,
    output ads_dev_pkg::octosample_t         octosample,
    output logic                             adc_reset,
    output logic                             convsta,
    output logic                             convstb,
    output logic                             cs_n,
    output logic                             rd_n,
    output ads_dev_pkg::oversamprat_t        os,
    output ads_dev_pkg::range_t              range,
    output ads_dev_pkg::ref_source_t         refsel,
    output logic                             stby_n
);

    logic ready;
    logic readout_start;
    logic readout_done;

    // Static configuration pins
    assign os     = oversamprat;
    assign range  = adc_range;
    assign refsel = ref_source;
    // Never enter standby
    assign stby_n = 1'b1;

    power_up_sequencer #(
        .RESET_HIGH_CLKS(RESET_HIGH_CLKS),
        .POSTRESET_CLKS (POSTRESET_CLKS)
    ) u_power_up (
        .clk      (clk),
        .reset_sn (reset_sn),
        .adc_reset(adc_reset),
        .ready    (ready)
    );

    conversion_sequencer #(
        .SAMPLE_CYC_CLKS(SAMPLE_CYC_CLKS),
        .CONVST_CLKS    (CONVST_CLKS)
    ) u_conversion (
        .clk          (clk),
        .reset_sn     (reset_sn),
        .ready        (ready),
        .busy         (busy),
        .readout_done (readout_done),
        .convsta      (convsta),
        .convstb      (convstb),
        .conv_cnt     (conv_cnt),
        .readout_start(readout_start)
    );

    // Sixteen reads per conversion, result held until the next one
    readout_engine #(
        .RDDB_CLKS  (RDDB_CLKS),
        .HOLD_CLKS  (HOLD_CLKS),
        .RD_LOW_CLKS(RD_LOW_CLKS)
    ) u_readout (
        .clk             (clk),
        .reset_sn        (reset_sn),
        .readout_start   (readout_start),
        .db              (db),
        .cs_n            (cs_n),
        .rd_n            (rd_n),
        .readout_done    (readout_done),
        .octosample      (octosample),
        .octosample_valid(octosample_valid),
        .samp_cnt        (samp_cnt)
    );

endmodule

// File: src/ads_drv_pkg.sv
// ADC driver state definitions

package ads_drv_pkg;

    // Power-up sequence
    typedef enum logic [1:0] {
        pwr_idle,
        pwr_reset_high,
        pwr_settle,
        pwr_done
    } power_state_t;

    // Conversion sequence, one pass per sample period
    typedef enum logic [2:0] {
        conv_wait_period,
        conv_convst,
        conv_convst_hold,
        conv_wait_not_busy,
        conv_reading
    } conv_state_t;

    // One read operation on the parallel bus
    typedef enum logic [1:0] {
        rd_idle,
        rd_setup,
        rd_hold,
        rd_low
    } read_state_t;

    // Two read operations per channel
    // Even index reads the top 16 bits, odd index the bottom 2
    typedef logic [$clog2(2 * ads_dev_pkg::chan_cnt)-1:0] read_op_ix_t;

endpackage

// File: src/conversion_sequencer.sv
// ADC conversion start sequencer
`timescale 1ns/10ps

module conversion_sequencer #(
    parameter int SAMPLE_CYC_CLKS = 100,
    parameter int CONVST_CLKS     = 2
) (
    input  logic clk,
    input  logic reset_sn,
    input  logic ready,
    input  logic busy,
    input  logic readout_done,
    output logic convsta,
    output logic convstb,
    output logic conv_cnt,
    output logic readout_start
);

    localparam int PER_W  = $clog2(SAMPLE_CYC_CLKS + 1);
    localparam int HOLD_W = $clog2(CONVST_CLKS + 1);

    ads_drv_pkg::conv_state_t state;

    // Sample period, counts down to zero and waits there
    logic [PER_W-1:0]  period_cnt;
    // Minimum convst high time after busy is seen
    logic [HOLD_W-1:0] hold_cnt;

    // BUSY comes from the ADC clock domain
    logic busy_meta;
    logic busy_sync;

    always_ff @(posedge clk) begin
        if (!reset_sn) begin
            busy_meta <= 1'b0;
            busy_sync <= 1'b0;
        end else begin
            busy_meta <= busy;
            busy_sync <= busy_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_sn) begin
            state         <= ads_drv_pkg::conv_wait_period;
            period_cnt    <= '0;
            hold_cnt      <= '0;
            conv_cnt      <= 1'b0;
            readout_start <= 1'b0;
        end else begin
            readout_start <= 1'b0;
            // Period keeps running in every state, readout included
            if (period_cnt != '0) begin
                period_cnt <= period_cnt - 1'b1;
            end
            case (state)
                ads_drv_pkg::conv_wait_period: begin
                    if (ready && period_cnt == '0) begin
                        state      <= ads_drv_pkg::conv_convst;
                        period_cnt <= PER_W'(SAMPLE_CYC_CLKS - 1);
                        // Marks the start of a new acquisition
                        conv_cnt   <= ~conv_cnt;
                    end
                end
                // Hold convst until the ADC reports busy
                ads_drv_pkg::conv_convst: begin
                    if (busy_sync) begin
                        state    <= ads_drv_pkg::conv_convst_hold;
                        hold_cnt <= HOLD_W'(CONVST_CLKS - 1);
                    end
                end
                ads_drv_pkg::conv_convst_hold: begin
                    if (hold_cnt == '0) begin
                        state <= ads_drv_pkg::conv_wait_not_busy;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                // End of conversion kicks off the readout
                ads_drv_pkg::conv_wait_not_busy: begin
                    if (!busy_sync) begin
                        state         <= ads_drv_pkg::conv_reading;
                        readout_start <= 1'b1;
                    end
                end
                // No new convst while the bus is being read
                ads_drv_pkg::conv_reading: begin
                    if (readout_done) begin
                        state <= ads_drv_pkg::conv_wait_period;
                    end
                end
                default: begin
                    state <= ads_drv_pkg::conv_wait_period;
                end
            endcase
        end
    end

    // Both convst pins share one strobe
    assign convsta = (state == ads_drv_pkg::conv_convst) ||
                     (state == ads_drv_pkg::conv_convst_hold);
    assign convstb = convsta;

endmodule

// File: src/power_up_sequencer.sv
// ADC power-up sequencer
`timescale 1ns/10ps

module power_up_sequencer #(
    parameter int RESET_HIGH_CLKS = 2500,
    parameter int POSTRESET_CLKS  = 1250
) (
    input  logic clk,
    input  logic reset_sn,
    output logic adc_reset,
    output logic ready
);

    // One down-counter shared by both waits
    localparam int CNT_MAX = (RESET_HIGH_CLKS > POSTRESET_CLKS) ?
                             RESET_HIGH_CLKS : POSTRESET_CLKS;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    ads_drv_pkg::power_state_t state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!reset_sn) begin
            state <= ads_drv_pkg::pwr_idle;
            cnt   <= '0;
        end else begin
            case (state)
                // First clock out of reset starts the reset pulse
                ads_drv_pkg::pwr_idle: begin
                    state <= ads_drv_pkg::pwr_reset_high;
                    cnt   <= CNT_W'(RESET_HIGH_CLKS - 1);
                end
                // ADC held in reset
                ads_drv_pkg::pwr_reset_high: begin
                    if (cnt == '0) begin
                        state <= ads_drv_pkg::pwr_settle;
                        cnt   <= CNT_W'(POSTRESET_CLKS - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // Reset released, wait before the first convst
                ads_drv_pkg::pwr_settle: begin
                    if (cnt == '0) begin
                        state <= ads_drv_pkg::pwr_done;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // Stay here until the next reset
                ads_drv_pkg::pwr_done: begin
                    state <= ads_drv_pkg::pwr_done;
                end
                default: begin
                    state <= ads_drv_pkg::pwr_idle;
                end
            endcase
        end
    end

    // Both outputs decode straight from the state register
    assign adc_reset = (state == ads_drv_pkg::pwr_reset_high);
    assign ready     = (state == ads_drv_pkg::pwr_done);

endmodule

// File: src/readout_engine.sv
// ADC parallel bus readout
`timescale 1ns/10ps

module readout_engine #(
    parameter int RDDB_CLKS   = 2,
    parameter int HOLD_CLKS   = 1,
    parameter int RD_LOW_CLKS = 1
) (
    input  logic                               clk,
    input  logic                               reset_sn,
    input  logic                               readout_start,
    input  logic [ads_dev_pkg::db_width-1:0]   db,
    output logic                               cs_n,
    output logic                               rd_n,
    output logic                               readout_done,
    output ads_dev_pkg::octosample_t           octosample,
    output logic                               octosample_valid,
    output logic                               samp_cnt
);

    // Phase counter covers the longest of the three phases
    localparam int PH_MAX_A = (RDDB_CLKS > HOLD_CLKS) ? RDDB_CLKS : HOLD_CLKS;
    localparam int PH_MAX   = (PH_MAX_A > RD_LOW_CLKS) ? PH_MAX_A : RD_LOW_CLKS;
    localparam int PH_W     = $clog2(PH_MAX + 1);

    ads_drv_pkg::read_state_t state;
    logic [PH_W-1:0]          phase_cnt;
    ads_drv_pkg::read_op_ix_t op_ix;

    // Top 16 bits of the channel in flight
    logic [ads_dev_pkg::db_width-1:0] hi_word;
    // Completed channels shift down, newest enters at the top
    ads_dev_pkg::octosample_t         partial;

    ads_dev_pkg::chan_ix_t cur_chan;
    logic                  capture;
    logic                  phase_end;
    logic                  last_op;

    assign cur_chan  = op_ix[$bits(op_ix)-1:1];
    assign phase_end = (phase_cnt == '0);
    // Bus sampled on the last cycle of the setup phase
    assign capture   = (state == ads_drv_pkg::rd_setup) && phase_end;
    assign last_op   = op_ix[0] &&
                       (cur_chan == ads_dev_pkg::chan_ix_t'(ads_dev_pkg::chan_cnt - 1));

    // Ends the low phase of the sixteenth read
    assign readout_done = (state == ads_drv_pkg::rd_low) && phase_end && last_op;

    always_ff @(posedge clk) begin
        if (!reset_sn) begin
            state     <= ads_drv_pkg::rd_idle;
            phase_cnt <= '0;
            op_ix     <= '0;
        end else begin
            if (!phase_end) begin
                phase_cnt <= phase_cnt - 1'b1;
            end
            case (state)
                ads_drv_pkg::rd_idle: begin
                    if (readout_start) begin
                        state     <= ads_drv_pkg::rd_setup;
                        phase_cnt <= PH_W'(RDDB_CLKS - 1);
                        op_ix     <= '0;
                    end
                end
                // Strobes low, waiting for valid data on DB
                ads_drv_pkg::rd_setup: begin
                    if (phase_end) begin
                        state     <= ads_drv_pkg::rd_hold;
                        phase_cnt <= PH_W'(HOLD_CLKS - 1);
                    end
                end
                // Strobes still low for data hold
                ads_drv_pkg::rd_hold: begin
                    if (phase_end) begin
                        state     <= ads_drv_pkg::rd_low;
                        phase_cnt <= PH_W'(RD_LOW_CLKS - 1);
                    end
                end
                // Strobes high between reads
                ads_drv_pkg::rd_low: begin
                    if (phase_end) begin
                        if (last_op) begin
                            state <= ads_drv_pkg::rd_idle;
                        end else begin
                            state     <= ads_drv_pkg::rd_setup;
                            phase_cnt <= PH_W'(RDDB_CLKS - 1);
                            op_ix     <= op_ix + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ads_drv_pkg::rd_idle;
                end
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (capture) begin
            if (!op_ix[0]) begin
                hi_word <= db;
            end else begin
                // Low 2 bits arrive on DB[15:14]
                partial <= {{hi_word, db[15:14]}, partial[ads_dev_pkg::chan_cnt-1:1]};
            end
        end
        if (readout_done) begin
            octosample <= partial;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_sn) begin
            octosample_valid <= 1'b0;
            samp_cnt         <= 1'b0;
        end else if (readout_done) begin
            octosample_valid <= 1'b1;
            samp_cnt         <= ~samp_cnt;
        end
    end

    // CS and RD driven together, low through setup and hold
    assign cs_n = !((state == ads_drv_pkg::rd_setup) || (state == ads_drv_pkg::rd_hold));
    assign rd_n = cs_n;

endmodule

// File: verif/adc_model.sv
// Behavioral parallel-output ADC
`timescale 1ns/10ps

module adc_model #(
    parameter int BUSY_DELAY_CLKS = 3,
    parameter int CONV_CLKS       = 25
) (
    input  logic                                                      clk,
    input  logic                                                      convst,
    input  logic                                                      cs_n,
    input  logic                                                      rd_n,
    output logic                                                      busy,
    output logic [ads_dev_pkg::db_width-1:0]                          db,
    output logic [ads_dev_pkg::chan_cnt*ads_dev_pkg::sample_width-1:0] drawn,
    output logic                                                      drawn_tgl
);

    localparam int W = ads_dev_pkg::sample_width;

    int seed;
    // Bus words waiting for read strobes, in read order
    logic [ads_dev_pkg::db_width-1:0] word_q[$];
    logic served;

    // Eight new channel values, split into two bus words each
    task automatic draw_conversion();
        logic [31:0]          rnd;
        ads_dev_pkg::sample_t val;
        for (int ch = 0; ch < ads_dev_pkg::chan_cnt; ch++) begin
            rnd = $random(seed);
            val = rnd[W-1:0];
            drawn[ch*W +: W] <= val;
            word_q.push_back(val[W-1:2]);
            // Bottom bits on DB[15:14], zeros below
            word_q.push_back({val[1:0], 14'b0});
        end
        drawn_tgl <= ~drawn_tgl;
    endtask

    initial begin
        seed      = 74;
        busy      = 1'b0;
        db        = '0;
        drawn     = '0;
        drawn_tgl = 1'b0;
        served    = 1'b0;
        forever begin
            @(posedge convst);
            // Busy follows convst after a short delay
            repeat (BUSY_DELAY_CLKS) @(negedge clk);
            busy <= 1'b1;
            repeat (CONV_CLKS) @(negedge clk);
            draw_conversion();
            busy <= 1'b0;
        end
    end

    // One word per read strobe, held until the next strobe
    always @(negedge clk) begin
        if (!cs_n && !rd_n) begin
            if (!served) begin
                if (word_q.size() != 0) begin
                    db <= word_q.pop_front();
                end else begin
                    db <= 'x;
                end
                served <= 1'b1;
            end
        end else begin
            served <= 1'b0;
        end
    end

endmodule

// File: verif/tb_ads_driver.sv
// ADC driver testbench
`timescale 1ns/10ps

module tb_ads_driver;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_CONV        = 12;
    localparam int RESET_HIGH_CLKS = 20;
    localparam int POSTRESET_CLKS  = 10;
    localparam int SAMPLE_CYC_CLKS = 150;
    localparam int CONVST_CLKS     = 2;
    localparam int RDDB_CLKS       = 2;
    localparam int HOLD_CLKS       = 1;
    localparam int RD_LOW_CLKS     = 1;
    localparam int READ_OPS        = 2 * ads_dev_pkg::chan_cnt;
    localparam int READOUT_CLKS    = READ_OPS * (RDDB_CLKS + HOLD_CLKS + RD_LOW_CLKS);
    localparam int WATCHDOG_CYCLES = 2 * (30 + NUM_CONV * (SAMPLE_CYC_CLKS + READOUT_CLKS));

    localparam ads_dev_pkg::oversamprat_t OS_SET    = ads_dev_pkg::oversamprat_4;
    localparam ads_dev_pkg::range_t       RANGE_SET = ads_dev_pkg::range_5v;
    localparam ads_dev_pkg::ref_source_t  REF_SET   = ads_dev_pkg::ref_source_external;

    logic                                                      clk;
    logic                                                      reset_sn;
    logic                                                      busy;
    logic [ads_dev_pkg::db_width-1:0]                          db;
    logic                                                      conv_cnt;
    logic                                                      samp_cnt;
    logic                                                      octosample_valid;
    ads_dev_pkg::octosample_t                                  octosample;
    logic                                                      adc_reset;
    logic                                                      convsta;
    logic                                                      convstb;
    logic                                                      cs_n;
    logic                                                      rd_n;
    ads_dev_pkg::oversamprat_t                                 os;
    ads_dev_pkg::range_t                                       range;
    ads_dev_pkg::ref_source_t                                  refsel;
    logic                                                      stby_n;
    logic [ads_dev_pkg::chan_cnt*ads_dev_pkg::sample_width-1:0] drawn;
    logic                                                      drawn_tgl;

    // Monitor state updated on the falling edge
    int  cyc = 0;
    int  rst_hi_cnt = 0;
    int  rst_fall_cyc = 0;
    int  last_rise_cyc = -SAMPLE_CYC_CLKS;
    int  low_len = 0;
    int  reads_in_conv = 0;
    int  result_due = 0;
    int  n_results = 0;
    logic prev_convst = 1'b0;
    logic prev_cs_n = 1'b1;
    logic prev_tgl = 1'b0;
    logic busy_seen = 1'b0;
    logic exp_conv = 1'b0;
    logic exp_samp = 1'b0;
    logic exp_valid = 1'b0;
    ads_dev_pkg::octosample_t exp_q[$];
    ads_dev_pkg::octosample_t exp_res;

    ads_driver_top #(
        .oversamprat    (OS_SET),
        .ref_source     (REF_SET),
        .adc_range      (RANGE_SET),
        .RESET_HIGH_CLKS(RESET_HIGH_CLKS),
        .POSTRESET_CLKS (POSTRESET_CLKS),
        .SAMPLE_CYC_CLKS(SAMPLE_CYC_CLKS),
        .CONVST_CLKS    (CONVST_CLKS),
        .RDDB_CLKS      (RDDB_CLKS),
        .HOLD_CLKS      (HOLD_CLKS),
        .RD_LOW_CLKS    (RD_LOW_CLKS)
    ) uut (
        .clk(clk), .reset_sn(reset_sn), .busy(busy), .db(db),
        .conv_cnt(conv_cnt), .samp_cnt(samp_cnt), .octosample_valid(octosample_valid),
        .octosample(octosample), .adc_reset(adc_reset), .convsta(convsta),
        .convstb(convstb), .cs_n(cs_n), .rd_n(rd_n), .os(os), .range(range),
        .refsel(refsel), .stby_n(stby_n)
    );

    adc_model model (
        .clk(clk), .convst(convsta), .cs_n(cs_n), .rd_n(rd_n), .busy(busy), .db(db),
        .drawn(drawn), .drawn_tgl(drawn_tgl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic flag_violation(input string what);
        $display("Check failed at cycle %0d: %s", cyc, what);
        stop_run();
    endtask

    task automatic check_sample(input string name, input ads_dev_pkg::sample_t exp,
                                input ads_dev_pkg::sample_t act);
        if (exp !== act) begin
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_os(input string name, input ads_dev_pkg::oversamprat_t exp,
                            input ads_dev_pkg::oversamprat_t act);
        if (exp !== act) begin
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // Channel ch of a conversion lands in slot ch of the result
    function automatic ads_dev_pkg::octosample_t expected_octosample(
        input logic [ads_dev_pkg::chan_cnt*ads_dev_pkg::sample_width-1:0] raw);
        ads_dev_pkg::octosample_t res;
        for (int ch = 0; ch < ads_dev_pkg::chan_cnt; ch++) begin
            res[ch] = raw[ch*ads_dev_pkg::sample_width +: ads_dev_pkg::sample_width];
        end
        return res;
    endfunction

    task automatic compare_result();
        if (exp_q.size() == 0) begin
            flag_violation("a result arrived with no conversion data pending");
        end
        exp_res = exp_q.pop_front();
        for (int ch = 0; ch < ads_dev_pkg::chan_cnt; ch++) begin
            check_sample($sformatf("conversion %0d channel %0d", n_results, ch),
                         exp_res[ch], octosample[ch]);
        end
        exp_samp  = ~exp_samp;
        exp_valid = 1'b1;
        n_results = n_results + 1;
    endtask

    // Outputs sampled on the falling edge where they are stable
    always @(negedge clk) begin
        if (reset_sn) begin
            cyc = cyc + 1;
            check_os("os pins", OS_SET, os);
            check_bit("range pin", RANGE_SET, range);
            check_bit("refsel pin", REF_SET, refsel);
            check_bit("stby_n pin", 1'b1, stby_n);
            check_bit("convstb follows convsta", convsta, convstb);
            check_bit("rd_n follows cs_n", cs_n, rd_n);
            // Reset pulse starts on the first clock out of reset
            if (cyc == 1) begin
                check_bit("adc_reset after release", 1'b1, adc_reset);
            end
            if (adc_reset) begin
                if (rst_fall_cyc != 0) begin
                    flag_violation("adc_reset rose again after the power-up pulse");
                end
                rst_hi_cnt = rst_hi_cnt + 1;
            end else if (rst_hi_cnt != 0 && rst_fall_cyc == 0) begin
                rst_fall_cyc = cyc;
                if (rst_hi_cnt != RESET_HIGH_CLKS) begin
                    flag_violation($sformatf("adc_reset was high for %0d cycles", rst_hi_cnt));
                end
            end
            if ((convsta || !cs_n) &&
                (rst_fall_cyc == 0 || cyc - rst_fall_cyc < POSTRESET_CLKS)) begin
                flag_violation("convst or read strobe before the settle time ended");
            end
            // New conversion data from the model
            if (drawn_tgl != prev_tgl) begin
                exp_q.push_back(expected_octosample(drawn));
                prev_tgl = drawn_tgl;
            end
            // Result shows RD_LOW_CLKS cycles after the last strobe rises
            if (result_due != 0) begin
                result_due = result_due - 1;
                if (result_due == 0) begin
                    compare_result();
                end
            end
            check_bit("samp_cnt", exp_samp, samp_cnt);
            check_bit("octosample_valid", exp_valid, octosample_valid);
            // Conversion start
            if (convsta && !prev_convst) begin
                if (cyc - last_rise_cyc < SAMPLE_CYC_CLKS) begin
                    flag_violation("convst rises closer than the sample period");
                end
                if (reads_in_conv != 0) begin
                    flag_violation("convst rose without a complete 16-read readout");
                end
                last_rise_cyc = cyc;
                exp_conv      = ~exp_conv;
                busy_seen     = 1'b0;
            end
            if (convsta && busy) begin
                busy_seen = 1'b1;
            end
            if (!convsta && prev_convst && !busy_seen) begin
                flag_violation("convst fell before busy was raised");
            end
            check_bit("conv_cnt", exp_conv, conv_cnt);
            prev_convst = convsta;
            // Read strobes
            if (!cs_n) begin
                low_len = low_len + 1;
                if (busy) begin
                    flag_violation("read strobe while busy is high");
                end
            end else if (!prev_cs_n) begin
                if (low_len != RDDB_CLKS + HOLD_CLKS) begin
                    flag_violation($sformatf("read strobe low for %0d cycles", low_len));
                end
                low_len       = 0;
                reads_in_conv = reads_in_conv + 1;
                if (reads_in_conv == READ_OPS) begin
                    reads_in_conv = 0;
                    result_due    = RD_LOW_CLKS;
                end
            end
            prev_cs_n = cs_n;
        end
    end

    initial begin
        clk      = 1'b0;
        reset_sn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_sn <= 1'b1;
        wait (n_results == NUM_CONV);
        repeat (4) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog sized from the sample period and readout length
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d results", cyc, n_results);
        stop_run();
    end

endmodule
